/* compile.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_stage_if.sv
verilog/rv_alu.sv
verilog/rv_decoder.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_exec_top.sv
bench/rv_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module rv_exec_tb -f compile.f -o rv_exec_sim
./obj_dir/rv_exec_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

/* bench/rv_exec_tb.sv */
`include "rv_core_macros.svh"

module rv_exec_tb;

    localparam int OPC_OPI   = 'h13;
    localparam int OPC_JALR  = 'h67;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    instr;
        logic [`RV_XLEN-1:0]    pc;
        logic                   wb;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    value;
        logic                   redirect;
        logic [`RV_XLEN-1:0]    redirect_pc;
        logic [1:0]             gap;
    } test_t;

    logic                   I_clk = 1'b0;
    logic                   rst_n;
    logic                   instr_valid;
    logic [`RV_XLEN-1:0]    instr;
    logic [`RV_XLEN-1:0]    pc;
    logic                   result_valid;
    logic                   result_wb;
    logic [`RV_REG_AW-1:0]  result_rd;
    logic [`RV_XLEN-1:0]    result_value;
    logic                   redirect;
    logic [`RV_XLEN-1:0]    redirect_pc;

    test_t                  tests[$];
    string                  names[$];
    int                     pend_q[$];
    int                     due_q[$];
    logic [`RV_XLEN-1:0]    xr [0:31];
    integer                 seed = 32'h957f04e3;
    int                     cyc = 0;
    int                     mismatch_count = 0;
    int                     other_count = 0;
    logic                   built = 1'b0;

    rv_exec_top rv_exec_top_i (
        .I_clk        (I_clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .result_valid (result_valid),
        .result_wb    (result_wb),
        .result_rd    (result_rd),
        .result_value (result_value),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    always #2 I_clk = ~I_clk;

    always @(posedge I_clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] itype_word(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] rtype_word(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] btype_word(int f3, int rs1, int rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jtype_word(int rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
    endfunction

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // Branch rule on the funct3 code
    function automatic logic branch_taken(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void add_test(string name, logic [31:0] word, logic [31:0] at_pc,
                                     logic wb, int rd, logic [31:0] value, logic redir,
                                     logic [31:0] target, int gap);
        test_t t;
        t.instr       = word;
        t.pc          = at_pc;
        t.wb          = wb;
        t.rd          = rd[4:0];
        t.value       = value;
        t.redirect    = redir;
        t.redirect_pc = target;
        t.gap         = gap[1:0];
        // Track the architectural registers for later expectations
        if (wb && rd != 0) begin
            xr[rd] = value;
        end
        tests.push_back(t);
        names.push_back(name);
    endfunction

    function automatic void queue_alu_test(string name, logic [31:0] word, int rd,
                                           logic [31:0] value, int gap);
        add_test(name, word, 32'h0, rd != 0, rd, (rd != 0) ? value : 32'h0, 1'b0, 32'h0, gap);
    endfunction

    function automatic void queue_branch_test(string name, int f3, int rs1, int rs2);
        logic [31:0] at_pc;
        logic [31:0] rnd;
        logic [12:0] off;
        at_pc = random_word();
        at_pc[1:0] = 2'b00;
        rnd = random_word();
        off = {rnd[12:2], 2'b00};
        add_test(name, btype_word(f3, rs1, rs2, off), at_pc, 1'b0, 0, 32'h0,
                 branch_taken(f3, xr[rs1], xr[rs2]), at_pc + {{19{off[12]}}, off}, 3);
    endfunction

    function automatic void build_tests();
        logic [31:0] at_pc;
        logic [31:0] rnd;
        logic [20:0] joff;
        logic [31:0] sum;
        foreach (xr[i]) begin
            xr[i] = '0;
        end
        // Preload from x0
        queue_alu_test("addi_x1", itype_word(OPC_OPI, 0, 1, 0, 5), 1, 32'd5, 3);
        queue_alu_test("addi_x2", itype_word(OPC_OPI, 0, 2, 0, -7), 2, 32'hFFFF_FFF9, 3);
        queue_alu_test("addi_x3", itype_word(OPC_OPI, 0, 3, 0, 3), 3, 32'd3, 3);
        queue_alu_test("addi_x4", itype_word(OPC_OPI, 0, 4, 0, -2048), 4, 32'hFFFF_F800, 3);
        queue_alu_test("addi", itype_word(OPC_OPI, 0, 5, 1, -12), 5, xr[1] + 32'hFFFF_FFF4, 3);
        queue_alu_test("slti", itype_word(OPC_OPI, 2, 6, 2, -3), 6,
                       32'($signed(xr[2]) < -3), 3);
        queue_alu_test("sltiu", itype_word(OPC_OPI, 3, 7, 1, -1), 7,
                       32'(xr[1] < 32'hFFFF_FFFF), 3);
        queue_alu_test("xori", itype_word(OPC_OPI, 4, 8, 2, 'h0F0), 8, xr[2] ^ 32'h0F0, 3);
        queue_alu_test("srai", itype_word(OPC_OPI, 5, 9, 2, 'h402), 9,
                       32'($signed(xr[2]) >>> 2), 3);
        queue_alu_test("srli", itype_word(OPC_OPI, 5, 10, 2, 4), 10, xr[2] >> 4, 3);
        queue_alu_test("lui", {20'hABCDE, 5'd11, 7'h37}, 11, 32'hABCD_E000, 3);
        add_test("auipc", {20'h12345, 5'd12, 7'h17}, 32'h100, 1'b1, 12,
                 32'h1234_5000 + 32'h100, 1'b0, 32'h0, 3);
        // Register-register operations
        queue_alu_test("add", rtype_word(0, 0, 13, 1, 2), 13, xr[1] + xr[2], 3);
        queue_alu_test("sub", rtype_word('h20, 0, 14, 1, 2), 14, xr[1] - xr[2], 3);
        queue_alu_test("sll", rtype_word(0, 1, 15, 2, 3), 15, xr[2] << xr[3][4:0], 3);
        queue_alu_test("slt", rtype_word(0, 2, 16, 2, 1), 16,
                       32'($signed(xr[2]) < $signed(xr[1])), 3);
        queue_alu_test("sltu", rtype_word(0, 3, 17, 2, 1), 17, 32'(xr[2] < xr[1]), 3);
        queue_alu_test("xor", rtype_word(0, 4, 18, 1, 2), 18, xr[1] ^ xr[2], 3);
        queue_alu_test("srl", rtype_word(0, 5, 19, 2, 3), 19, xr[2] >> xr[3][4:0], 3);
        queue_alu_test("sra", rtype_word('h20, 5, 20, 2, 3), 20,
                       32'($signed(xr[2]) >>> xr[3][4:0]), 3);
        queue_alu_test("or", rtype_word(0, 6, 21, 1, 4), 21, xr[1] | xr[4], 3);
        queue_alu_test("and", rtype_word(0, 7, 22, 2, 4), 22, xr[2] & xr[4], 3);
        // Each condition taken and not taken with x1 = 5 and x2 = -7
        queue_branch_test("beq_taken", 0, 1, 1);
        queue_branch_test("beq_not", 0, 1, 2);
        queue_branch_test("bne_taken", 1, 1, 2);
        queue_branch_test("bne_not", 1, 1, 1);
        queue_branch_test("blt_taken", 4, 2, 1);
        queue_branch_test("blt_not", 4, 1, 2);
        queue_branch_test("bge_taken", 5, 1, 2);
        queue_branch_test("bge_not", 5, 2, 1);
        queue_branch_test("bltu_taken", 6, 1, 2);
        queue_branch_test("bltu_not", 6, 2, 1);
        queue_branch_test("bgeu_taken", 7, 2, 1);
        queue_branch_test("bgeu_not", 7, 1, 2);
        // Jumps link PC plus 4
        at_pc = random_word();
        at_pc[1:0] = 2'b00;
        rnd = random_word();
        joff = {rnd[20:2], 2'b00};
        add_test("jal", jtype_word(23, joff), at_pc, 1'b1, 23, at_pc + 32'd4, 1'b1,
                 at_pc + {{11{joff[20]}}, joff}, 3);
        at_pc = random_word();
        at_pc[1:0] = 2'b00;
        sum = xr[1] + 32'd8;
        add_test("jalr", itype_word(OPC_JALR, 0, 24, 1, 8), at_pc, 1'b1, 24, at_pc + 32'd4,
                 1'b1, {sum[31:1], 1'b0}, 3);
        // x0 stays zero and the store opcode is ignored
        queue_alu_test("addi_x0", itype_word(OPC_OPI, 0, 0, 1, 9), 0, xr[1] + 32'd9, 3);
        queue_alu_test("read_x0", rtype_word(0, 0, 25, 0, 1), 25, xr[0] + xr[1], 3);
        // sw x2, 4(x1)
        add_test("store", 32'h0020_A223, 32'h0, 1'b0, 0, 32'h0, 1'b0, 32'h0, 3);
        // Back-to-back independent strobes
        queue_alu_test("pipe_addi", itype_word(OPC_OPI, 0, 26, 1, 1), 26, xr[1] + 32'd1, 1);
        queue_alu_test("pipe_xori", itype_word(OPC_OPI, 4, 27, 2, 'h55), 27,
                       xr[2] ^ 32'h55, 1);
        queue_alu_test("pipe_ori", itype_word(OPC_OPI, 6, 28, 4, 'h0F), 28, xr[4] | 32'h0F, 3);
    endfunction

    task automatic check_result(input int idx, input int due);
        test_t t;
        t = tests[idx];
        assert (cyc == due) else begin
            $display("result for %s came in cycle %0d instead of cycle %0d", names[idx], cyc, due);
            other_count++;
        end
        assert (result_wb === t.wb) else begin
            $display("mismatch %s result_wb expected %b actual %b", names[idx], t.wb, result_wb);
            mismatch_count++;
        end
        if (t.wb) begin
            assert (result_rd === t.rd) else begin
                $display("mismatch %s result_rd expected %0d actual %0d",
                         names[idx], t.rd, result_rd);
                mismatch_count++;
            end
        end
        assert (result_value === t.value) else begin
            $display("mismatch %s result_value expected %h actual %h",
                     names[idx], t.value, result_value);
            mismatch_count++;
        end
        assert (redirect === t.redirect) else begin
            $display("mismatch %s redirect expected %b actual %b",
                     names[idx], t.redirect, redirect);
            mismatch_count++;
        end
        if (t.redirect) begin
            assert (redirect_pc === t.redirect_pc) else begin
                $display("mismatch %s redirect_pc expected %h actual %h",
                         names[idx], t.redirect_pc, redirect_pc);
                mismatch_count++;
            end
        end
    endtask

    // Registered outputs are sampled mid-cycle
    always @(negedge I_clk) begin
        if (rst_n && result_valid) begin
            assert (pend_q.size() != 0) else begin
                $display("result_valid rose in cycle %0d with no instruction pending", cyc);
                other_count++;
            end
            if (pend_q.size() != 0) begin
                check_result(pend_q.pop_front(), due_q.pop_front());
            end
        end
    end

    initial begin
        int limit;
        wait (built);
        // Reset, four cycles per entry and some slack
        limit = 10 + tests.size() * 4 + 20;
        repeat (limit) @(posedge I_clk);
        $display("timeout after %0d cycles with %0d results still pending", limit, pend_q.size());
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        build_tests();
        built = 1'b1;
        repeat (10) @(posedge I_clk);
        rst_n <= 1'b1;
        @(negedge I_clk);
        assert (result_valid === 1'b0 && result_wb === 1'b0 && redirect === 1'b0) else begin
            $display("outputs were not cleared by reset");
            other_count++;
        end
        foreach (tests[i]) begin
            @(posedge I_clk);
            instr_valid <= 1'b1;
            instr       <= tests[i].instr;
            pc          <= tests[i].pc;
            pend_q.push_back(i);
            // Strobe cycle is cyc plus 1 and the result is due 3 cycles later
            due_q.push_back(cyc + 4);
            repeat (int'(tests[i].gap) - 1) begin
                @(posedge I_clk);
                instr_valid <= 1'b0;
            end
        end
        @(posedge I_clk);
        instr_valid <= 1'b0;
        while (pend_q.size() != 0) begin
            @(posedge I_clk);
        end
        repeat (4) @(posedge I_clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog/rv_exec_top.sv */
`include "rv_core_macros.svh"

module rv_exec_top (
    input  logic                   I_clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [`RV_XLEN-1:0]    instr,
    input  logic [`RV_XLEN-1:0]    pc,
    output logic                   result_valid,
    output logic                   result_wb,
    output logic [`RV_REG_AW-1:0]  result_rd,
    output logic [`RV_XLEN-1:0]    result_value,
    output logic                   redirect,
    output logic [`RV_XLEN-1:0]    redirect_pc
);
    import rv_ctrl_pkg::*;

    logic [`RV_REG_AW-1:0]  rs1_addr;
    logic [`RV_REG_AW-1:0]  rs2_addr;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;

    rv_stage_if #(.payload_t(dec_ctrl_t))   dec2exe ();
    rv_stage_if #(.payload_t(exe_result_t)) exe2res ();

    rv_decoder decoder_i (
        .I_clk       (I_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec_out     (dec2exe.producer)
    );

    rv_execute execute_i (
        .I_clk   (I_clk),
        .rst_n   (rst_n),
        .dec_in  (dec2exe.consumer),
        .exe_out (exe2res.producer)
    );

    // Register file reads are combinational back into decode
    rv_writeback writeback_i (
        .I_clk        (I_clk),
        .rst_n        (rst_n),
        .res_in       (exe2res.consumer),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result_valid (result_valid),
        .result_wb    (result_wb),
        .result_rd    (result_rd),
        .result_value (result_value),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

/* verilog/rv_writeback.sv */
`include "rv_core_macros.svh"

module rv_writeback (
    input  logic                   I_clk,
    input  logic                   rst_n,
    rv_stage_if.consumer           res_in,
    input  logic [`RV_REG_AW-1:0]  rs1_addr,
    input  logic [`RV_REG_AW-1:0]  rs2_addr,
    output logic [`RV_XLEN-1:0]    rs1_data,
    output logic [`RV_XLEN-1:0]    rs2_data,
    output logic                   result_valid,
    output logic                   result_wb,
    output logic [`RV_REG_AW-1:0]  result_rd,
    output logic [`RV_XLEN-1:0]    result_value,
    output logic                   redirect,
    output logic [`RV_XLEN-1:0]    redirect_pc
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];
    logic                do_wb;

    assign do_wb = res_in.wb && (res_in.rd != '0);

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge I_clk) begin
        if (res_in.valid && do_wb) begin
            regs[res_in.rd] <= res_in.payload.value;
        end
    end

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_wb    <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            result_valid <= res_in.valid;
            if (res_in.valid) begin
                result_wb <= do_wb;
                redirect  <= res_in.payload.redirect;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (res_in.valid) begin
            result_rd    <= res_in.rd;
            result_value <= do_wb ? res_in.payload.value : '0;
            redirect_pc  <= res_in.payload.redirect_pc;
        end
    end

endmodule

/* verilog/rv_execute.sv */
`include "rv_core_macros.svh"

module rv_execute (
    input  logic           I_clk,
    input  logic           rst_n,
    rv_stage_if.consumer   dec_in,
    rv_stage_if.producer   exe_out
);
    import rv_ctrl_pkg::*;

    dec_ctrl_t            c;
    exe_result_t          res;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;
    logic [`RV_XLEN-1:0]  alu_y;
    logic [`RV_XLEN-1:0]  jalr_sum;
    logic                 eq;
    logic                 lt;
    logic                 ltu;
    logic [5:0]           cond;

    assign c    = dec_in.payload;
    assign op_a = (c.op_a_sel == OPA_PC) ? c.pc : c.rs1_val;
    assign op_b = (c.op_b_sel == OPB_IMM) ? c.imm : c.rs2_val;

    rv_alu alu_i (
        .op (c.alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_y)
    );

    // Branch conditions in mask order, BEQ in bit 0
    assign eq   = (c.rs1_val == c.rs2_val);
    assign lt   = ($signed(c.rs1_val) < $signed(c.rs2_val));
    assign ltu  = (c.rs1_val < c.rs2_val);
    assign cond = {~ltu, ltu, ~lt, lt, ~eq, eq};

    assign jalr_sum = c.rs1_val + c.imm;

    always_comb begin
        res.value       = c.is_jump ? c.pc + `RV_XLEN'd4 : alu_y;
        res.redirect    = (|(cond & c.branch_mask)) | c.is_jump;
        res.redirect_pc = c.is_jalr ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : c.pc + c.imm;
    end

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            exe_out.valid <= 1'b0;
        end else begin
            exe_out.valid <= dec_in.valid;
        end
    end

    always_ff @(posedge I_clk) begin
        if (dec_in.valid) begin
            exe_out.rd      <= dec_in.rd;
            exe_out.wb      <= dec_in.wb;
            exe_out.payload <= res;
        end
    end

endmodule

/* verilog/rv_decoder.sv */
`include "rv_core_macros.svh"

module rv_decoder (
    input  logic                   I_clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [`RV_XLEN-1:0]    instr,
    input  logic [`RV_XLEN-1:0]    pc,
    output logic [`RV_REG_AW-1:0]  rs1_addr,
    output logic [`RV_REG_AW-1:0]  rs2_addr,
    input  logic [`RV_XLEN-1:0]    rs1_data,
    input  logic [`RV_XLEN-1:0]    rs2_data,
    rv_stage_if.producer           dec_out
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // STORE opcode, only its S-form immediate is decoded
    localparam logic [4:0] STORE_OPC = 5'b01000;

    logic [4:0]  opc;
    logic [2:0]  funct3;
    logic        is_op;
    logic        wb;
    dec_ctrl_t   ctrl;

    assign opc    = instr[6:2];
    assign funct3 = instr[14:12];
    assign is_op  = (opc == OP);

    // LUI becomes x0 plus immediate
    assign rs1_addr = (opc == LUI) ? '0 : instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        case (opc)
            STORE_OPC:  ctrl.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH:     ctrl.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            LUI, AUIPC: ctrl.imm = {instr[31:12], 12'b0};
            JAL:        ctrl.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:    ctrl.imm = {{20{instr[31]}}, instr[31:20]};
        endcase

        case (opc)
            OP, OPIMM, LUI, AUIPC, JAL, JALR: wb = 1'b1;
            default:                          wb = 1'b0;
        endcase

        ctrl.op_a_sel = (opc == JAL || opc == AUIPC) ? OPA_PC : OPA_RS1;
        ctrl.op_b_sel = (is_op || opc == BRANCH) ? OPB_RS2 : OPB_IMM;

        // Only OP and OP-IMM pick an operation, everything else adds
        ctrl.alu_op = ADD;
        if (is_op || opc == OPIMM) begin
            case (funct3)
                F3_ADD_SUB: ctrl.alu_op = (is_op && instr[30]) ? SUB : ADD;
                F3_SLL:     ctrl.alu_op = SLL;
                F3_SLT:     ctrl.alu_op = SLT;
                F3_SLTU:    ctrl.alu_op = SLTU;
                F3_XOR:     ctrl.alu_op = XOR;
                F3_SRL_SRA: ctrl.alu_op = instr[30] ? SRA : SRL;
                F3_OR:      ctrl.alu_op = OR;
                F3_AND:     ctrl.alu_op = AND;
            endcase
        end

        ctrl.branch_mask = '0;
        if (opc == BRANCH) begin
            case (funct3)
                F3_BEQ:  ctrl.branch_mask[0] = 1'b1;
                F3_BNE:  ctrl.branch_mask[1] = 1'b1;
                F3_BLT:  ctrl.branch_mask[2] = 1'b1;
                F3_BGE:  ctrl.branch_mask[3] = 1'b1;
                F3_BLTU: ctrl.branch_mask[4] = 1'b1;
                F3_BGEU: ctrl.branch_mask[5] = 1'b1;
                default: ctrl.branch_mask = '0;
            endcase
        end

        ctrl.is_jump = (opc == JAL || opc == JALR);
        ctrl.is_jalr = (opc == JALR);
        ctrl.pc      = pc;
        ctrl.rs1_val = rs1_data;
        ctrl.rs2_val = rs2_data;
    end

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            dec_out.valid <= 1'b0;
        end else begin
            dec_out.valid <= instr_valid;
        end
    end

    always_ff @(posedge I_clk) begin
        if (instr_valid) begin
            dec_out.rd      <= instr[11:7];
            dec_out.wb      <= wb;
            dec_out.payload <= ctrl;
        end
    end

endmodule

/* verilog/rv_alu.sv */
`include "rv_core_macros.svh"

module rv_alu (
    input  rv_isa_pkg::alu_op_t   op,
    input  logic [`RV_XLEN-1:0]   a,
    input  logic [`RV_XLEN-1:0]   b,
    output logic [`RV_XLEN-1:0]   y
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (op)
            ADD:     y = a + b;
            SUB:     y = a - b;
            SLL:     y = a << shamt;
            SLT:     y = {{(`RV_XLEN-1){1'b0}}, lt};
            SLTU:    y = {{(`RV_XLEN-1){1'b0}}, ltu};
            XOR:     y = a ^ b;
            SRL:     y = a >> shamt;
            // Arithmetic shift keeps the sign bit
            SRA:     y = $signed(a) >>> shamt;
            OR:      y = a | b;
            AND:     y = a & b;
            default: y = a + b;
        endcase
    end

endmodule

/* verilog/rv_stage_if.sv */
`include "rv_core_macros.svh"

interface rv_stage_if #(
    parameter type payload_t = logic
);

    logic                   valid;
    logic [`RV_REG_AW-1:0]  rd;
    logic                   wb;
    payload_t               payload;

    modport producer (
        output valid, rd, wb, payload
    );

    modport consumer (
        input valid, rd, wb, payload
    );

endinterface

/* verilog/rv_ctrl_pkg.sv */
`include "rv_core_macros.svh"

package rv_ctrl_pkg;

    typedef enum logic {OPA_RS1 = 1'b0, OPA_PC = 1'b1} op_a_sel_t;

    typedef enum logic {OPB_RS2 = 1'b0, OPB_IMM = 1'b1} op_b_sel_t;

    // Control word from decode to execute
    typedef struct packed {
        rv_isa_pkg::alu_op_t  alu_op;
        op_a_sel_t            op_a_sel;
        op_b_sel_t            op_b_sel;
        logic [5:0]           branch_mask;  // BGEU BLTU BGE BLT BNE BEQ
        logic                 is_jump;
        logic                 is_jalr;
        logic [`RV_XLEN-1:0]  imm;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  rs1_val;
        logic [`RV_XLEN-1:0]  rs2_val;
    } dec_ctrl_t;

    // Outcome from execute to the result stage
    typedef struct packed {
        logic [`RV_XLEN-1:0]  value;
        logic                 redirect;
        logic [`RV_XLEN-1:0]  redirect_pc;
    } exe_result_t;

endpackage

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OP     = 5'b01100,
        OPIMM  = 5'b00100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001
    } opcode_t;

    // Function-3 codes for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Function-3 codes for the branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

endpackage

/* verilog/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Width of data words, addresses and the PC
`define RV_XLEN 32

// Width of a register index, 32 architectural registers
`define RV_REG_AW 5

`endif
